// File: build.f
+incdir+dv
logic/isaPkg.sv
logic/ctrlPkg.sv
logic/decodeCtrl.sv
logic/aluOpDecode.sv
logic/flowDecode.sv
logic/memDecode.sv
logic/decodeTop.sv
dv/decodeTb.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = decodeTb
FILELIST = build.f
OBJDIR   = obj_dir
BIN      = $(OBJDIR)/V$(TOP)
SRCS     = $(shell grep -v '^+' $(FILELIST)) dv/decodeModel.svh

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJDIR)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJDIR)

// File: dv/decodeModel.svh
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

//////////////////////////////////////////////////
// expected bundle for one input item
//////////////////////////////////////////////////

function automatic decodedItemT expectDecode(inItemT it);
    decodedItemT d;
    logic [5:0]  op;
    logic [5:0]  fn;
    logic [4:0]  rt;
    logic        isLoad;
    logic        isStore;
    logic        isAluImm;
    logic        isBranch;
    logic        taken;
    op       = it.instr.rFmt.opcode;
    fn       = it.instr.rFmt.funct;
    rt       = it.instr.iFmt.rt;
    d        = '0;
    isLoad   = op inside {opLb, opLh, opLw, opLbu, opLhu};
    isStore  = op inside {opSb, opSh, opSw};
    isAluImm = op inside {opAddi, opAddiu, opSlti, opSltiu, opAndi, opOri, opXori, opLui};
    isBranch = (op inside {opBeq, opBne, opBlez, opBgtz})
               || (op == opRegimm && (rt inside {rtBltz, rtBgez, rtBltzal, rtBgezal}));
    case (op)
        opBeq:    taken = it.flags.zero;
        opBne:    taken = !it.flags.zero;
        opBlez:   taken = it.flags.lessEqZero;
        opBgtz:   taken = !it.flags.lessEqZero;
        opRegimm: taken = isBranch && (it.flags.lessZero == (rt inside {rtBltz, rtBltzal}));
        default:  taken = 1'b0;
    endcase
    if (op == opSpecial)
    begin
        d.alu.legal = 1'b1;
        case (fn)
            fnSll, fnSllv: d.alu.aluOp = aluSll;
            fnSrl, fnSrlv: d.alu.aluOp = aluSrl;
            fnSra, fnSrav: d.alu.aluOp = aluSra;
            fnAdd, fnAddu: d.alu.aluOp = aluAdd;
            fnSub, fnSubu: d.alu.aluOp = aluSub;
            fnAnd:         d.alu.aluOp = aluAnd;
            fnOr:          d.alu.aluOp = aluOr;
            fnXor:         d.alu.aluOp = aluXor;
            fnNor:         d.alu.aluOp = aluNor;
            fnSlt, fnSltu: d.alu.aluOp = aluSlt;
            fnJr, fnJalr:  d.alu.aluOp = aluPassA;
            default:       d.alu.legal = 1'b0;
        endcase
        d.alu.regDst = 1'b1;
        d.alu.aluWre = !(fn inside {fnJr, fnJalr});
        d.alu.srcA   = fn inside {fnSll, fnSrl, fnSra};
        d.alu.sign   = fn inside {fnAdd, fnSub, fnSlt};
        d.flow.pcSel = (fn inside {fnJr, fnJalr}) ? pcReg : pcSeq;
        d.flow.link  = (fn == fnJalr);
    end
    else
    begin
        d.alu.legal  = isLoad || isStore || isAluImm || isBranch || (op inside {opJ, opJal});
        d.alu.srcB   = isLoad || isStore || isAluImm;
        d.alu.extSel = isStore
                       || (op inside {opAddi, opAddiu, opSlti, opSltiu, opLb, opLh, opLbu, opLhu});
        d.alu.sign   = op inside {opAddi, opSlti, opLb, opLh};
        d.alu.regDst = isBranch;
        d.alu.aluWre = isAluImm;
        case (op)
            opSlti, opSltiu: d.alu.aluOp = aluSlt;
            opAndi:          d.alu.aluOp = aluAnd;
            opOri:           d.alu.aluOp = aluOr;
            opXori:          d.alu.aluOp = aluXor;
            opLui:           d.alu.aluOp = aluLui;
            default:         d.alu.aluOp = isLoad ? aluLoadAddr : (isBranch ? aluSub : aluAdd);
        endcase
        if (op inside {opJ, opJal})
            d.flow.pcSel = pcJump;
        else if (taken)
            d.flow.pcSel = pcBranch;
        d.flow.link = (op == opJal)
                      || (taken && op == opRegimm && (rt inside {rtBltzal, rtBgezal}));
        d.mem.read  = isLoad;
        d.mem.write = isStore;
        if (op inside {opLb, opLbu, opSb})
            d.mem.width = widByte;
        else if (op inside {opLh, opLhu, opSh})
            d.mem.width = widHalf;
    end
    if (!d.alu.legal)
        d = '0;                                   // unknown word, all controls off
    return d;
endfunction

// 16 bit fibonacci, taps 16 14 13 11
function automatic logic lfsrStep();
    logic fb;
    fb        = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
    lfsrState = {lfsrState[14:0], fb};
    return fb;
endfunction

function automatic logic [31:0] randBits(int n);
    logic [31:0] v;
    int          i;
    v = '0;
    for (i = 0; i < n; i++)
        v = {v[30:0], lfsrStep()};
    return v;
endfunction

task automatic checkAlu(string name, aluCtrlT exp, aluCtrlT act);
    if (exp !== act)
        failRun($sformatf("Fail %s alu: expected %h, actual %h", name, exp, act));
endtask

task automatic checkFlow(string name, flowCtrlT exp, flowCtrlT act);
    if (exp !== act)
        failRun($sformatf("Fail %s flow: expected %h, actual %h", name, exp, act));
endtask

task automatic checkMem(string name, memCtrlT exp, memCtrlT act);
    if (exp !== act)
        failRun($sformatf("Fail %s mem: expected %h, actual %h", name, exp, act));
endtask

`endif

// File: dv/decodeTb.sv
`timescale 1ns/1ps

module decodeTb;
    import isaPkg::*;
    import ctrlPkg::*;

    typedef struct packed {
        decodedItemT item;
        int          sentEdge;
        logic        measureLat;
    } expEntryT;

    logic        clk = 1'b0;
    logic        rstN;
    logic        inValid = 1'b0;
    inItemT      inItem = '0;
    logic        inCredit;
    logic        outValid;
    decodedItemT outItem;
    logic        outCredit = 1'b0;

    logic [15:0] lfsrState = 16'd99;
    string       testName = "reset";
    int          edgeCnt = 0;
    int          upCredits = inCreditDepth;
    int          creditPulses = 0;
    int          accepted = 0;
    logic        measureLat = 1'b0;
    inItemT      sendQ[$];
    expEntryT    expQ[$];
    int          holdQ[$];                        // release edge per queued item
    int          delayQ[$];
    logic [16:0] kept[$];                         // opcode, rt, funct

    task automatic failRun(string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "first error, run stopped");
    endtask

    `include "decodeModel.svh"

    decodeTop u_dut (
        .clk       (clk),
        .rstN      (rstN),
        .inValid   (inValid),
        .inItem    (inItem),
        .inCredit  (inCredit),
        .outValid  (outValid),
        .outItem   (outItem),
        .outCredit (outCredit)
    );

    always #10 clk = ~clk;

    always @(posedge clk)
        edgeCnt <= edgeCnt + 1;

    //////////////////////////////////////////////////
    // upstream and downstream credit models
    //////////////////////////////////////////////////

    always @(negedge clk)
    begin : upstream
        inItemT   it;
        expEntryT e;
        if (!rstN)
            inValid <= 1'b0;
        else
        begin
            if (inCredit)
            begin
                if (upCredits >= inCreditDepth)
                    failRun("inCredit returned while upstream held all its credits");
                upCredits    = upCredits + 1;
                creditPulses = creditPulses + 1;
            end
            if (sendQ.size() != 0 && upCredits > 0)
            begin
                it           = sendQ.pop_front();
                e.item       = expectDecode(it);
                e.sentEdge   = edgeCnt;
                e.measureLat = measureLat;
                expQ.push_back(e);
                inItem      <= it;
                inValid     <= 1'b1;
                upCredits    = upCredits - 1;
                accepted     = accepted + 1;
            end
            else
                inValid <= 1'b0;
        end
    end

    // execute queue, drains in order
    always @(negedge clk)
    begin : downstream
        int delay;
        if (!rstN)
            outCredit <= 1'b0;
        else
        begin
            if (outValid)
            begin
                if (holdQ.size() >= outCreditDepth)
                    failRun("more than four items outstanding in the execute queue");
                delay = (delayQ.size() != 0) ? delayQ.pop_front() : 0;
                holdQ.push_back(edgeCnt + delay);
            end
            if (holdQ.size() != 0 && holdQ[0] <= edgeCnt)
            begin
                void'(holdQ.pop_front());
                outCredit <= 1'b1;
            end
            else
                outCredit <= 1'b0;
        end
    end

    always @(negedge clk)
    begin : compare
        expEntryT e;
        if (rstN && outValid)
        begin
            if (expQ.size() == 0)
                failRun("outValid raised with no item outstanding");
            else
            begin
                e = expQ.pop_front();
                checkAlu(testName, e.item.alu, outItem.alu);
                checkFlow(testName, e.item.flow, outItem.flow);
                checkMem(testName, e.item.mem, outItem.mem);
                if (e.measureLat && edgeCnt != e.sentEdge + 2)
                    failRun($sformatf("Fail %s latency: expected %0d, actual %0d",
                                      testName, e.sentEdge + 2, edgeCnt));
            end
        end
    end

    //////////////////////////////////////////////////
    // stimulus helpers
    //////////////////////////////////////////////////

    // fixed fields come from the table, the rest from the LFSR
    function automatic inItemT itemFromKept(logic [16:0] k, condFlagsT fl);
        inItemT it;
        it.instr.rFmt.opcode = k[16:11];
        it.instr.rFmt.rs     = 5'(randBits(5));
        it.instr.rFmt.rt     = (k[16:11] == opRegimm) ? k[10:6] : 5'(randBits(5));
        it.instr.rFmt.rd     = 5'(randBits(5));
        it.instr.rFmt.shamt  = 5'(randBits(5));
        it.instr.rFmt.funct  = (k[16:11] == opSpecial) ? k[5:0] : 6'(randBits(6));
        it.flags             = fl;
        return it;
    endfunction

    task automatic buildKept();
        logic [5:0] fns[18];
        logic [5:0] ops[22];
        logic [4:0] rts[4];
        int         i;
        fns = '{fnSll, fnSrl, fnSra, fnSllv, fnSrlv, fnSrav, fnJr, fnJalr, fnAdd,
                fnAddu, fnSub, fnSubu, fnAnd, fnOr, fnXor, fnNor, fnSlt, fnSltu};
        ops = '{opAddi, opAddiu, opSlti, opSltiu, opAndi, opOri, opXori, opLui,
                opLb, opLh, opLw, opLbu, opLhu, opSb, opSh, opSw,
                opJ, opJal, opBeq, opBne, opBlez, opBgtz};
        rts = '{rtBltz, rtBgez, rtBltzal, rtBgezal};
        for (i = 0; i < 18; i++)
            kept.push_back({opSpecial, 5'd0, fns[i]});
        for (i = 0; i < 22; i++)
            kept.push_back({ops[i], 5'd0, 6'd0});
        for (i = 0; i < 4; i++)
            kept.push_back({opRegimm, rts[i], 6'd0});
    endtask

    // every sent item has come out and been released downstream
    task automatic drain();
        int waited;
        waited = 0;
        while (sendQ.size() != 0 || expQ.size() != 0 || holdQ.size() != 0)
        begin
            @(posedge clk);
            waited++;
            if (waited > 3000)
                failRun($sformatf("timeout: %s did not drain from the pipeline", testName));
        end
        if (creditPulses != accepted)
            failRun($sformatf("Fail %s credits: expected %0d, actual %0d",
                              testName, accepted, creditPulses));
    endtask

    //////////////////////////////////////////////////
    // tests
    //////////////////////////////////////////////////

    initial
    begin : tests
        int          i;
        int          f;
        condFlagsT   fl;
        logic [16:0] unknown[11];
        rstN = 1'b0;
        repeat (8) @(negedge clk);
        rstN = 1'b1;
        repeat (4)
        begin
            @(negedge clk);
            if (outValid || inCredit)
                failRun("outValid or inCredit went high before any item was sent");
        end

        testName   = "keptSet";
        measureLat = 1'b1;
        buildKept();
        for (i = 0; i < kept.size(); i++)
            sendQ.push_back(itemFromKept(kept[i], 3'b000));
        drain();

        testName = "branchFlags";
        for (i = 0; i < kept.size(); i++)
            if (kept[i][16:11] inside {opBeq, opBne, opBlez, opBgtz, opRegimm})
                for (f = 0; f < 8; f++)
                    sendQ.push_back(itemFromKept(kept[i], 3'(f)));
        drain();

        testName   = "randomStream";
        measureLat = 1'b0;
        for (i = 0; i < 200; i++)
        begin
            fl = 3'(randBits(3));
            sendQ.push_back(itemFromKept(kept[randBits(6) % kept.size()], fl));
            delayQ.push_back(int'(randBits(2)));  // release within 3 cycles
        end
        drain();

        testName = "unknownCodes";
        unknown  = '{{6'h10, 5'd0, 6'd0}, {6'h1c, 5'd0, 6'd0}, {6'h22, 5'd0, 6'd0},
                     {6'h3f, 5'd0, 6'd0}, {opSpecial, 5'd0, 6'h01},
                     {opSpecial, 5'd0, 6'h10}, {opSpecial, 5'd0, 6'h18},
                     {opSpecial, 5'd0, 6'h0b}, {opRegimm, 5'b00010, 6'd0},
                     {opRegimm, 5'b10011, 6'd0}, {opRegimm, 5'b11111, 6'd0}};
        for (i = 0; i < 11; i++)
        begin
            fl = 3'(randBits(3));
            sendQ.push_back(itemFromKept(unknown[i], fl));
        end
        drain();

        $display(">>> PASS");
        $finish;
    end

endmodule

// File: logic/decodeTop.sv
`timescale 1ns/1ps

module decodeTop (
    input  logic                clk,
    input  logic                rstN,
    input  logic                inValid,
    input  ctrlPkg::inItemT     inItem,
    output logic                inCredit,
    output logic                outValid,
    output ctrlPkg::decodedItemT outItem,
    input  logic                outCredit
);
    import ctrlPkg::*;

    inItemT stage1Item;
    logic   loadOut;

    decodeCtrl u_ctrl (
        .clk        (clk),
        .rstN       (rstN),
        .inValid    (inValid),
        .inItem     (inItem),
        .inCredit   (inCredit),
        .outCredit  (outCredit),
        .stage1Item (stage1Item),
        .loadOut    (loadOut),
        .outValid   (outValid)
    );

    aluOpDecode u_alu (
        .clk        (clk),
        .rstN       (rstN),
        .stage1Item (stage1Item),
        .loadOut    (loadOut),
        .alu        (outItem.alu)
    );

    flowDecode u_flow (
        .clk        (clk),
        .rstN       (rstN),
        .stage1Item (stage1Item),
        .loadOut    (loadOut),
        .flow       (outItem.flow)
    );

    memDecode u_mem (
        .clk        (clk),
        .rstN       (rstN),
        .stage1Item (stage1Item),
        .loadOut    (loadOut),
        .mem        (outItem.mem)
    );

endmodule

// File: logic/memDecode.sv
`timescale 1ns/1ps

module memDecode (
    input  logic             clk,
    input  logic             rstN,
    input  ctrlPkg::inItemT  stage1Item,
    input  logic             loadOut,
    output ctrlPkg::memCtrlT mem
);
    import isaPkg::*;
    import ctrlPkg::*;

    logic [5:0] opcode;
    memCtrlT    nxt;

    assign opcode = stage1Item.instr.iFmt.opcode;

    always_comb
    begin
        nxt.read  = opcode inside {opLb, opLh, opLw, opLbu, opLhu};
        nxt.write = opcode inside {opSb, opSh, opSw};
        case (opcode)
            opLb, opLbu, opSb: nxt.width = widByte;
            opLh, opLhu, opSh: nxt.width = widHalf;
            default:           nxt.width = widWord;   // also the idle value
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rstN)
            mem <= '0;
        else if (loadOut)
            mem <= nxt;
    end

    noReadWrite: assert property (@(posedge clk) disable iff (!rstN)
        !(mem.read && mem.write));

endmodule

// File: logic/flowDecode.sv
`timescale 1ns/1ps

module flowDecode (
    input  logic              clk,
    input  logic              rstN,
    input  ctrlPkg::inItemT   stage1Item,
    input  logic              loadOut,
    output ctrlPkg::flowCtrlT flow
);
    import isaPkg::*;
    import ctrlPkg::*;

    instrWordT instr;
    condFlagsT flags;
    flowCtrlT  nxt;
    logic      taken;

    assign instr = stage1Item.instr;
    assign flags = stage1Item.flags;

    always_comb
    begin
        nxt   = '0;
        taken = 1'b0;
        case (instr.rFmt.opcode)
            opJ:  nxt.pcSel = pcJump;
            opJal:
            begin
                nxt.pcSel = pcJump;
                nxt.link  = 1'b1;
            end
            opSpecial:
            begin
                if (instr.rFmt.funct inside {fnJr, fnJalr})
                    nxt.pcSel = pcReg;
                nxt.link = instr.rFmt.funct == fnJalr;
            end
            opBeq:  taken = flags.zero;
            opBne:  taken = !flags.zero;
            opBlez: taken = flags.lessEqZero;
            opBgtz: taken = !flags.lessEqZero;
            opRegimm:
            begin
                case (instr.iFmt.rt)
                    rtBltz, rtBltzal: taken = flags.lessZero;
                    rtBgez, rtBgezal: taken = !flags.lessZero;
                    default:          taken = 1'b0;
                endcase
                nxt.link = taken && (instr.iFmt.rt inside {rtBltzal, rtBgezal});
            end
            default: nxt = '0;
        endcase
        if (taken)
            nxt.pcSel = pcBranch;
    end

    always_ff @(posedge clk)
    begin
        if (!rstN)
            flow <= '0;
        else if (loadOut)
            flow <= nxt;
    end

    linkHasTarget: assert property (@(posedge clk) disable iff (!rstN)
        flow.link |-> flow.pcSel != pcSeq);

endmodule

// File: logic/aluOpDecode.sv
`timescale 1ns/1ps

module aluOpDecode (
    input  logic             clk,
    input  logic             rstN,
    input  ctrlPkg::inItemT  stage1Item,
    input  logic             loadOut,
    output ctrlPkg::aluCtrlT alu
);
    import isaPkg::*;
    import ctrlPkg::*;

    instrWordT instr;
    aluCtrlT   nxt;

    assign instr = stage1Item.instr;

    always_comb
    begin
        nxt = '0;                                     // unknown stays all zero
        case (instr.rFmt.opcode)
            opSpecial:
            begin
                nxt.legal  = 1'b1;
                nxt.regDst = 1'b1;
                nxt.aluWre = 1'b1;
                nxt.srcA   = instr.rFmt.funct inside {fnSll, fnSrl, fnSra};
                nxt.sign   = instr.rFmt.funct inside {fnAdd, fnSub, fnSlt};
                case (instr.rFmt.funct)
                    fnSll, fnSllv: nxt.aluOp = aluSll;
                    fnSrl, fnSrlv: nxt.aluOp = aluSrl;
                    fnSra, fnSrav: nxt.aluOp = aluSra;
                    fnAdd, fnAddu: nxt.aluOp = aluAdd;
                    fnSub, fnSubu: nxt.aluOp = aluSub;
                    fnAnd:         nxt.aluOp = aluAnd;
                    fnOr:          nxt.aluOp = aluOr;
                    fnXor:         nxt.aluOp = aluXor;
                    fnNor:         nxt.aluOp = aluNor;
                    fnSlt, fnSltu: nxt.aluOp = aluSlt;
                    fnJr, fnJalr:
                    begin
                        nxt.aluOp  = aluPassA;        // target comes from rs
                        nxt.aluWre = 1'b0;
                    end
                    default:       nxt = '0;
                endcase
            end
            opAddi, opAddiu, opSlti, opSltiu, opAndi, opOri, opXori, opLui:
            begin
                nxt.legal  = 1'b1;
                nxt.srcB   = 1'b1;
                nxt.aluWre = 1'b1;
                nxt.extSel = instr.iFmt.opcode inside {opAddi, opAddiu, opSlti, opSltiu};
                nxt.sign   = instr.iFmt.opcode inside {opAddi, opSlti};
                case (instr.iFmt.opcode)
                    opAddi, opAddiu: nxt.aluOp = aluAdd;
                    opSlti, opSltiu: nxt.aluOp = aluSlt;
                    opAndi:          nxt.aluOp = aluAnd;
                    opOri:           nxt.aluOp = aluOr;
                    opXori:          nxt.aluOp = aluXor;
                    default:         nxt.aluOp = aluLui;
                endcase
            end
            opLb, opLh, opLw, opLbu, opLhu:
            begin
                nxt.legal  = 1'b1;
                nxt.srcB   = 1'b1;
                nxt.aluOp  = aluLoadAddr;
                nxt.extSel = instr.iFmt.opcode != opLw;   // lw keeps imm zero extended
                nxt.sign   = instr.iFmt.opcode inside {opLb, opLh};
            end
            opSb, opSh, opSw:
            begin
                nxt.legal  = 1'b1;
                nxt.srcB   = 1'b1;
                nxt.extSel = 1'b1;
                nxt.aluOp  = aluAdd;
            end
            opJ, opJal:
            begin
                nxt.legal = 1'b1;
                nxt.aluOp = aluAdd;
            end
            opBeq, opBne, opBlez, opBgtz:
            begin
                nxt.legal  = 1'b1;
                nxt.regDst = 1'b1;
                nxt.aluOp  = aluSub;
            end
            opRegimm:
            begin
                if (instr.iFmt.rt inside {rtBltz, rtBgez, rtBltzal, rtBgezal})
                begin
                    nxt.legal  = 1'b1;
                    nxt.regDst = 1'b1;
                    nxt.aluOp  = aluSub;
                end
            end
            default: nxt = '0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            alu <= '0;
        end
        else if (loadOut)
        begin
            alu <= nxt;
        end
    end

endmodule

// File: logic/decodeCtrl.sv
`timescale 1ns/1ps

module decodeCtrl (
    input  logic            clk,
    input  logic            rstN,
    input  logic            inValid,
    input  ctrlPkg::inItemT inItem,
    output logic            inCredit,
    input  logic            outCredit,
    output ctrlPkg::inItemT stage1Item,
    output logic            loadOut,
    output logic            outValid
);
    import ctrlPkg::*;

    localparam int cntW = $clog2(outCreditDepth + 1);

    logic            stage1Valid;
    logic [cntW-1:0] outCnt;
    logic            creditAvail;
    logic            refill;

    //////////////////////////////////////////////////
    // stage advance
    //////////////////////////////////////////////////

    assign creditAvail = (outCnt != '0) || outCredit;   // returning credit usable now
    assign loadOut     = stage1Valid && creditAvail;
    assign refill      = !stage1Valid || loadOut;

    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            stage1Valid <= 1'b0;
        end
        else if (refill)
        begin
            stage1Valid <= inValid;
        end
    end

    always_ff @(posedge clk)
    begin
        if (refill && inValid)
        begin
            stage1Item <= inItem;
        end
    end

    // credit back upstream, output valid one cycle after the load
    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            inCredit <= 1'b0;
            outValid <= 1'b0;
        end
        else
        begin
            inCredit <= loadOut;
            outValid <= loadOut;
        end
    end

    //////////////////////////////////////////////////
    // downstream credits
    //////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            outCnt <= cntW'(outCreditDepth);
        end
        else
        begin
            outCnt <= outCnt - cntW'(loadOut) + cntW'(outCredit);
        end
    end

    cntBounded: assert property (@(posedge clk) disable iff (!rstN)
        outCnt <= cntW'(outCreditDepth));

    noExtraCredit: assert property (@(posedge clk) disable iff (!rstN)
        !(outCredit && outCnt == cntW'(outCreditDepth)));

    noOverrun: assert property (@(posedge clk) disable iff (!rstN)
        !(inValid && stage1Valid && !loadOut));       // upstream ignored its credits

endmodule

// File: logic/ctrlPkg.sv
package ctrlPkg;

    // operand compare results that travel with each word
    typedef struct packed {
        logic zero;                               // rs == rt
        logic lessEqZero;                         // rs <= 0
        logic lessZero;                           // rs < 0
    } condFlagsT;

    typedef struct packed {
        isaPkg::instrWordT instr;
        condFlagsT         flags;
    } inItemT;

    typedef logic [1:0] pcSelT;

    localparam pcSelT pcSeq    = 2'd0;
    localparam pcSelT pcJump   = 2'd1;
    localparam pcSelT pcBranch = 2'd2;
    localparam pcSelT pcReg    = 2'd3;

    typedef logic [1:0] memWidthT;

    localparam memWidthT widWord = 2'd0;
    localparam memWidthT widHalf = 2'd1;
    localparam memWidthT widByte = 2'd2;

    //////////////////////////////////////////////////
    // decoded control bundle
    //////////////////////////////////////////////////

    typedef struct packed {
        logic          legal;
        isaPkg::aluOpT aluOp;
        logic          sign;
        logic          srcA;                      // shamt as operand A
        logic          srcB;                      // immediate as operand B
        logic          extSel;                    // sign extend imm
        logic          regDst;                    // rd, not rt
        logic          aluWre;
    } aluCtrlT;

    typedef struct packed {
        pcSelT pcSel;
        logic  link;                              // write return address
    } flowCtrlT;

    typedef struct packed {
        logic     read;
        logic     write;
        memWidthT width;
    } memCtrlT;

    typedef struct packed {
        aluCtrlT  alu;
        flowCtrlT flow;
        memCtrlT  mem;
    } decodedItemT;

    localparam int inCreditDepth  = 2;            // one per pipeline stage
    localparam int outCreditDepth = 4;            // execute queue entries

endpackage

// File: logic/isaPkg.sv
package isaPkg;

    //////////////////////////////////////////////////
    // instruction word, R view and I view
    //////////////////////////////////////////////////

    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rFmtT;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;                       // branch condition for regimm
        logic [15:0] imm;
    } iFmtT;

    typedef union packed {
        rFmtT rFmt;
        iFmtT iFmt;
    } instrWordT;

    //////////////////////////////////////////////////
    // opcodes
    //////////////////////////////////////////////////

    localparam logic [5:0] opSpecial = 6'b000000;
    localparam logic [5:0] opRegimm  = 6'b000001;
    localparam logic [5:0] opJ       = 6'b000010;
    localparam logic [5:0] opJal     = 6'b000011;
    localparam logic [5:0] opBeq     = 6'b000100;
    localparam logic [5:0] opBne     = 6'b000101;
    localparam logic [5:0] opBlez    = 6'b000110;
    localparam logic [5:0] opBgtz    = 6'b000111;
    localparam logic [5:0] opAddi    = 6'b001000;
    localparam logic [5:0] opAddiu   = 6'b001001;
    localparam logic [5:0] opSlti    = 6'b001010;
    localparam logic [5:0] opSltiu   = 6'b001011;
    localparam logic [5:0] opAndi    = 6'b001100;
    localparam logic [5:0] opOri     = 6'b001101;
    localparam logic [5:0] opXori    = 6'b001110;
    localparam logic [5:0] opLui     = 6'b001111;
    localparam logic [5:0] opLb      = 6'b100000;
    localparam logic [5:0] opLh      = 6'b100001;
    localparam logic [5:0] opLw      = 6'b100011;
    localparam logic [5:0] opLbu     = 6'b100100;
    localparam logic [5:0] opLhu     = 6'b100101;
    localparam logic [5:0] opSb      = 6'b101000;
    localparam logic [5:0] opSh      = 6'b101001;
    localparam logic [5:0] opSw      = 6'b101011;

    // special group funct codes
    localparam logic [5:0] fnSll  = 6'b000000;
    localparam logic [5:0] fnSrl  = 6'b000010;
    localparam logic [5:0] fnSra  = 6'b000011;
    localparam logic [5:0] fnSllv = 6'b000100;
    localparam logic [5:0] fnSrlv = 6'b000110;
    localparam logic [5:0] fnSrav = 6'b000111;
    localparam logic [5:0] fnJr   = 6'b001000;
    localparam logic [5:0] fnJalr = 6'b001001;
    localparam logic [5:0] fnAdd  = 6'b100000;
    localparam logic [5:0] fnAddu = 6'b100001;
    localparam logic [5:0] fnSub  = 6'b100010;
    localparam logic [5:0] fnSubu = 6'b100011;
    localparam logic [5:0] fnAnd  = 6'b100100;
    localparam logic [5:0] fnOr   = 6'b100101;
    localparam logic [5:0] fnXor  = 6'b100110;
    localparam logic [5:0] fnNor  = 6'b100111;
    localparam logic [5:0] fnSlt  = 6'b101010;
    localparam logic [5:0] fnSltu = 6'b101011;

    localparam logic [4:0] rtBltz   = 5'b00000;
    localparam logic [4:0] rtBgez   = 5'b00001;
    localparam logic [4:0] rtBltzal = 5'b10000;
    localparam logic [4:0] rtBgezal = 5'b10001;

    //////////////////////////////////////////////////
    // ALU operation codes
    //////////////////////////////////////////////////

    typedef logic [4:0] aluOpT;

    localparam aluOpT aluAdd      = 5'd0;
    localparam aluOpT aluSub      = 5'd1;
    localparam aluOpT aluAnd      = 5'd2;
    localparam aluOpT aluOr       = 5'd3;
    localparam aluOpT aluXor      = 5'd4;
    localparam aluOpT aluNor      = 5'd5;
    localparam aluOpT aluSll      = 5'd7;
    localparam aluOpT aluSrl      = 5'd8;
    localparam aluOpT aluSra      = 5'd9;
    localparam aluOpT aluLoadAddr = 5'd10;
    localparam aluOpT aluLui      = 5'd11;
    localparam aluOpT aluSlt      = 5'd12;
    localparam aluOpT aluPassA    = 5'd18;        // result = operand A

endpackage
